// ==== verilog/corr_pkg.sv ====
//==================================================
// widths, register map and bus structs of the correlator
// word addresses are 8 bits, so every accumulator must
// sit below address 0x100
//==================================================
`default_nettype none

package corr_pkg;

	localparam int SAMPLE_WIDTH = 4;
	localparam int PROD_WIDTH = 2 * SAMPLE_WIDTH; // full signed product of two samples
	localparam int WB_ADR_WIDTH = 8;
	localparam int WB_DAT_WIDTH = 32;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [PROD_WIDTH-1:0] prod_t;
	typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;

	localparam wb_adr_t REG_CONTROL = 8'h00;
	localparam wb_adr_t REG_STATUS = 8'h01;
	localparam wb_adr_t REG_ACC_BASE = 8'h10; // baseline-major, most negative lag first

	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1; // write-only pulse, reads back 0

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_dat_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic enable;
		logic clear;
	} corr_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/sample_delay_line.sv ====
//==================================================
// tapped delay line for one input stream
// shifts on every sample_valid, even when the
// correlator is disabled; window[0] is the newest
//==================================================
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line #(
	parameter int LAG_COUNT = 3
) (
	input logic pllclk,
	input logic reset,
	input corr_pkg::sample_t sample,
	input logic sample_valid,
	output corr_pkg::sample_t [LAG_COUNT-1:0] window,
	output logic window_valid
);

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			window <= '0;
		end else if (sample_valid) begin
			window[0] <= sample;
			for (int i = 1; i < LAG_COUNT; i++) begin
				window[i] <= window[i-1]; // oldest sample drops off the end
			end
		end
	end

	// one cycle after the strobe the new sample sits in window[0]
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			window_valid <= 1'b0;
		end else begin
			window_valid <= sample_valid;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/baseline_accumulator.sv ====
//==================================================
// multiply-accumulate over all lags of one baseline
// ACC_WIDTH must be at least the product width (8)
// an accumulator that would overflow holds its value;
// the sticky overflow bit is released only by clear
//==================================================
`timescale 1ns/1ps
`default_nettype none

module baseline_accumulator #(
	parameter int LAG_COUNT = 3,
	parameter int ACC_WIDTH = 24,
	localparam int NUM_LAGS = 2 * LAG_COUNT - 1
) (
	input logic pllclk,
	input logic reset,
	input corr_pkg::sample_t [LAG_COUNT-1:0] window_a,
	input corr_pkg::sample_t [LAG_COUNT-1:0] window_b,
	input logic window_valid,
	input corr_pkg::corr_ctrl_t ctrl,
	output logic [NUM_LAGS*ACC_WIDTH-1:0] acc,
	output logic overflow
);

	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic signed [ACC_WIDTH:0] sum_t; // one guard bit to detect overflow

	corr_pkg::prod_t prod_d [NUM_LAGS];
	corr_pkg::prod_t prod_q [NUM_LAGS];
	acc_t acc_q [NUM_LAGS];
	sum_t sum [NUM_LAGS];
	logic [NUM_LAGS-1:0] fits;
	logic valid_q;

	for (genvar k = 0; k < NUM_LAGS; k++) begin : g_lag
		localparam int LAG = k - (LAG_COUNT - 1);
		if (LAG >= 0) begin : g_pos
			assign prod_d[k] = window_a[0] * window_b[LAG]; // b delayed against a
		end else begin : g_neg
			assign prod_d[k] = window_a[-LAG] * window_b[0];
		end
		assign sum[k] = acc_q[k] + prod_q[k];
		assign fits[k] = (sum[k][ACC_WIDTH] == sum[k][ACC_WIDTH-1]);
		assign acc[k*ACC_WIDTH +: ACC_WIDTH] = acc_q[k];
	end

	// stage 1: products and the enable-gated valid
	always_ff @(posedge pllclk) begin
		for (int k = 0; k < NUM_LAGS; k++) begin
			prod_q[k] <= prod_d[k];
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			valid_q <= 1'b0;
		end else if (ctrl.clear) begin
			valid_q <= 1'b0; // drop products already in flight
		end else begin
			valid_q <= window_valid & ctrl.enable;
		end
	end

	// stage 2: accumulate, clear wins over a pending product
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				acc_q[k] <= '0;
			end
			overflow <= 1'b0;
		end else if (ctrl.clear) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				acc_q[k] <= '0;
			end
			overflow <= 1'b0;
		end else if (valid_q) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				if (fits[k]) begin
					acc_q[k] <= sum[k][ACC_WIDTH-1:0];
				end
			end
			if (!(&fits)) begin
				overflow <= 1'b1; // any lag of this baseline saturating
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/corr_regs.sv ====
//==================================================
// Wishbone classic slave with control and readout
// zero wait state, ack lasts one cycle and is
// followed by at least one idle cycle
// writes take effect at the edge that ends the ack
//==================================================
`timescale 1ns/1ps
`default_nettype none

module corr_regs #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT = 3,
	parameter int ACC_WIDTH = 24,
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2,
	localparam int NUM_LAGS = 2 * LAG_COUNT - 1,
	localparam int NUM_ACCS = NUM_BASELINES * NUM_LAGS
) (
	input logic pllclk,
	input logic reset,
	input corr_pkg::wb_req_t wb_req,
	output corr_pkg::wb_rsp_t wb_rsp,
	input logic [NUM_ACCS*ACC_WIDTH-1:0] acc_all,
	input logic [NUM_BASELINES-1:0] overflow_all,
	output corr_pkg::corr_ctrl_t ctrl
);

	logic ack_q;
	logic enable_q;
	logic clear_q;
	logic req;
	logic ctrl_write;
	corr_pkg::wb_adr_t acc_idx;
	logic signed [ACC_WIDTH-1:0] acc_word;
	corr_pkg::wb_dat_t rd_data;

	assign req = wb_req.cyc & wb_req.stb;
	assign ctrl_write = req & wb_req.we & ack_q & (wb_req.adr == corr_pkg::REG_CONTROL);

	// offset into the flat accumulator vector, only meaningful inside the window
	assign acc_idx = wb_req.adr - corr_pkg::REG_ACC_BASE;
	assign acc_word = acc_all[acc_idx*ACC_WIDTH +: ACC_WIDTH];

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req & ~ack_q; // forces a gap between back-to-back cycles
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			enable_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			clear_q <= ctrl_write & wb_req.dat[corr_pkg::CTRL_CLEAR_BIT]; // one-cycle pulse
			if (ctrl_write) begin
				enable_q <= wb_req.dat[corr_pkg::CTRL_ENABLE_BIT];
			end
		end
	end

	// read data is driven from the held address, valid while ack is high
	always_comb begin
		rd_data = '0;
		if (wb_req.adr == corr_pkg::REG_CONTROL) begin
			rd_data[corr_pkg::CTRL_ENABLE_BIT] = enable_q;
		end else if (wb_req.adr == corr_pkg::REG_STATUS) begin
			rd_data[NUM_BASELINES-1:0] = overflow_all;
		end else if (wb_req.adr >= corr_pkg::REG_ACC_BASE && acc_idx < NUM_ACCS) begin
			rd_data = acc_word; // sign-extended to the bus width
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_data;

	assign ctrl.enable = enable_q;
	assign ctrl.clear = clear_q;

endmodule

`default_nettype wire

// ==== verilog/correlator_top.sv ====
//==================================================
// cross-correlator top level
// NUM_INPUTS >= 2, ACC_WIDTH from 8 to 32
// all inputs share one sample strobe and are never
// stalled, one sample per clock at most
//==================================================
`timescale 1ns/1ps
`default_nettype none

module correlator_top #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT = 3,
	parameter int ACC_WIDTH = 24
) (
	input logic pllclk,
	input logic reset,
	input corr_pkg::sample_t [NUM_INPUTS-1:0] samples,
	input logic sample_valid,
	input corr_pkg::wb_req_t wb_req,
	output corr_pkg::wb_rsp_t wb_rsp
);

	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_LAGS = 2 * LAG_COUNT - 1;
	localparam int BL_WIDTH = NUM_LAGS * ACC_WIDTH; // accumulator bits per baseline

	corr_pkg::sample_t [LAG_COUNT-1:0] window [NUM_INPUTS];
	logic [NUM_INPUTS-1:0] window_valid;
	logic [NUM_BASELINES*BL_WIDTH-1:0] acc_all;
	logic [NUM_BASELINES-1:0] overflow_all;
	corr_pkg::corr_ctrl_t ctrl;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_input
		sample_delay_line #(
			.LAG_COUNT(LAG_COUNT)
		) u_delay (
			.pllclk(pllclk),
			.reset(reset),
			.sample(samples[i]),
			.sample_valid(sample_valid),
			.window(window[i]),
			.window_valid(window_valid[i])
		);
	end

	// baselines numbered in lexical order (0,1) (0,2) ... (1,2) ...
	for (genvar a = 0; a < NUM_INPUTS - 1; a++) begin : g_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_b
			localparam int BL = a * (NUM_INPUTS - 1) - a * (a - 1) / 2 + (b - a - 1);
			baseline_accumulator #(
				.LAG_COUNT(LAG_COUNT),
				.ACC_WIDTH(ACC_WIDTH)
			) u_baseline (
				.pllclk(pllclk),
				.reset(reset),
				.window_a(window[a]),
				.window_b(window[b]),
				.window_valid(window_valid[0]), // all lines shift together
				.ctrl(ctrl),
				.acc(acc_all[BL*BL_WIDTH +: BL_WIDTH]),
				.overflow(overflow_all[BL])
			);
		end
	end

	corr_regs #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_COUNT(LAG_COUNT),
		.ACC_WIDTH(ACC_WIDTH)
	) u_regs (
		.pllclk(pllclk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.acc_all(acc_all),
		.overflow_all(overflow_all),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
//==================================================
// testbench clock and reset, 40 ns period
// reset is held low for 10 cycles and released
// on a falling edge
//==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic pllclk,
	output logic reset
);

	initial begin
		pllclk = 1'b0;
		forever #(HALF_PERIOD) pllclk = ~pllclk;
	end

	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge pllclk);
		@(negedge pllclk);
		reset = 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/correlator_asserts.sv ====
//==================================================
// Wishbone handshake and overflow properties
// bound into corr_regs and every baseline_accumulator
// failures are also counted in the testbench top
//==================================================
`timescale 1ns/1ps
`default_nettype none

module correlator_asserts (
	input logic pllclk,
	input logic reset,
	input corr_pkg::wb_req_t wb_req,
	input corr_pkg::wb_rsp_t wb_rsp,
	input logic clear,
	input logic overflow
);

	ack_needs_request: assert property (@(posedge pllclk) disable iff (!reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
	else begin
		$error("ack raised without cyc and stb");
		correlator_tb.assert_failures++;
	end

	ack_single_cycle: assert property (@(posedge pllclk) disable iff (!reset)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		$error("ack high for two cycles in a row");
		correlator_tb.assert_failures++;
	end

	ack_low_in_reset: assert property (@(posedge pllclk) !reset |=> !wb_rsp.ack)
	else begin
		$error("ack high during reset");
		correlator_tb.assert_failures++;
	end

	// sticky flag, only a clear pulse may release it
	overflow_release: assert property (@(posedge pllclk) disable iff (!reset)
		$fell(overflow) |-> $past(clear))
	else begin
		$error("overflow fell without a clear");
		correlator_tb.assert_failures++;
	end

endmodule

`default_nettype wire

// ==== test/correlator_tb.sv ====
//==================================================
// testbench for correlator_top with 12-bit accumulators
// samples and gaps come from $random with seed 20125
// registers are read only while the sample stream idles
//==================================================
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;

	localparam int NUM_INPUTS = 4;
	localparam int LAG_COUNT = 3;
	localparam int ACC_WIDTH = 12;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_LAGS = 2 * LAG_COUNT - 1;
	localparam int ACC_MAX = 2 ** (ACC_WIDTH - 1) - 1;
	localparam int ACC_MIN = -(2 ** (ACC_WIDTH - 1));
	localparam int ACK_TIMEOUT = 16;

	logic pllclk;
	logic reset;
	corr_pkg::sample_t [NUM_INPUTS-1:0] samples;
	logic sample_valid;
	corr_pkg::wb_req_t wb_req;
	corr_pkg::wb_rsp_t wb_rsp;

	integer seed = 20125;
	int hist [NUM_INPUTS][LAG_COUNT]; // index 0 is the newest sample
	int model_acc [NUM_BASELINES][NUM_LAGS];
	bit [NUM_BASELINES-1:0] model_ovf;
	bit model_enable;
	int checks;
	int errors;
	int test_errors;
	int assert_failures; // counted by the bound assertion modules

	tb_clock_gen u_clock (
		.pllclk(pllclk),
		.reset(reset)
	);

	correlator_top #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_COUNT(LAG_COUNT),
		.ACC_WIDTH(ACC_WIDTH)
	) DUT (
		.pllclk(pllclk),
		.reset(reset),
		.samples(samples),
		.sample_valid(sample_valid),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	bind corr_regs correlator_asserts u_asserts (
		.pllclk(pllclk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.clear(ctrl.clear),
		.overflow(|overflow_all)
	);

	bind baseline_accumulator correlator_asserts u_asserts (
		.pllclk(pllclk),
		.reset(reset),
		.wb_req('0),
		.wb_rsp('0),
		.clear(ctrl.clear),
		.overflow(overflow)
	);

	function automatic void clear_model();
		model_acc = '{default: 0};
		model_ovf = '0;
	endfunction

	// baselines in lexical pair order, lag index 0 is the most negative lag
	function automatic void shift_and_accumulate(input corr_pkg::sample_t [NUM_INPUTS-1:0] s);
		int bl;
		int lag;
		int prod;
		int sum;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int d = LAG_COUNT - 1; d > 0; d--) begin
				hist[i][d] = hist[i][d-1];
			end
			hist[i][0] = s[i];
		end
		if (!model_enable) return;
		bl = 0;
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					lag = k - (LAG_COUNT - 1);
					if (lag >= 0) begin
						prod = hist[a][0] * hist[b][lag];
					end else begin
						prod = hist[a][-lag] * hist[b][0];
					end
					sum = model_acc[bl][k] + prod;
					if (sum > ACC_MAX || sum < ACC_MIN) begin
						model_ovf[bl] = 1'b1; // accumulator holds its old value
					end else begin
						model_acc[bl][k] = sum;
					end
				end
				bl++;
			end
		end
	endfunction

	// called just after a falling edge, returns just after one
	task automatic bus_cycle(input logic we, input corr_pkg::wb_adr_t adr,
			input corr_pkg::wb_dat_t wdat, output corr_pkg::wb_dat_t rdat);
		int waited;
		waited = 0;
		rdat = '0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge pllclk);
			waited++;
		end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
		end else begin
			$display("no Wishbone ack at address 0x%02h after %0d cycles", adr, waited);
			errors++;
			test_errors++;
		end
		@(negedge pllclk); // request stays up through the edge that ends the ack
		wb_req = '0;
	endtask

	task automatic check_reg(input corr_pkg::wb_adr_t adr, input int expected);
		corr_pkg::wb_dat_t got;
		bus_cycle(1'b0, adr, '0, got);
		checks++;
		assert (got == expected) else begin
			$display("** Error at time %0t: address 0x%02h read 0x%08h, expected 0x%08h",
				$time, adr, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_model();
		check_reg(corr_pkg::REG_CONTROL, model_enable);
		check_reg(corr_pkg::REG_STATUS, model_ovf);
		for (int b = 0; b < NUM_BASELINES; b++) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				check_reg(corr_pkg::wb_adr_t'(corr_pkg::REG_ACC_BASE + b * NUM_LAGS + k),
					model_acc[b][k]);
			end
		end
	endtask

	task automatic write_control(input corr_pkg::wb_dat_t value);
		corr_pkg::wb_dat_t rdat;
		bus_cycle(1'b1, corr_pkg::REG_CONTROL, value, rdat);
		model_enable = value[corr_pkg::CTRL_ENABLE_BIT];
		if (value[corr_pkg::CTRL_CLEAR_BIT]) begin
			clear_model();
		end
		repeat (4) @(negedge pllclk); // clear pulse reaches the accumulators
	endtask

	task automatic send_samples(input int count, input bit extreme);
		int sent;
		sent = 0;
		while (sent < count) begin
			@(negedge pllclk);
			sample_valid = (($random(seed) & 3) != 0); // roughly one gap in four cycles
			if (sample_valid) begin
				for (int i = 0; i < NUM_INPUTS; i++) begin
					samples[i] = extreme ? corr_pkg::sample_t'(-8)
						: corr_pkg::sample_t'($random(seed));
				end
				shift_and_accumulate(samples);
				sent++;
			end
		end
		@(negedge pllclk);
		sample_valid = 1'b0;
		repeat (4) @(negedge pllclk); // let the pipeline drain before readback
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d failures", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		int waited;
		samples = '0;
		sample_valid = 1'b0;
		wb_req = '0;
		waited = 0;
		while (reset !== 1'b1 && waited < 40) begin
			@(negedge pllclk);
			waited++;
		end
		if (reset !== 1'b1) begin
			$display("reset was never released");
			errors++;
		end
		repeat (2) @(negedge pllclk);

		check_model();
		report_test("1 reset values");

		write_control(32'h1);
		check_reg(corr_pkg::REG_CONTROL, 1);
		write_control(32'h3);
		check_reg(corr_pkg::REG_CONTROL, 1);
		check_reg(8'h05, 0);
		check_reg(8'hff, 0);
		report_test("2 control readback");

		send_samples(200, 1'b0);
		check_model();
		report_test("3 random accumulation");

		write_control(32'h0);
		send_samples(50, 1'b0);
		check_model();
		write_control(32'h1);
		send_samples(50, 1'b0);
		check_model();
		report_test("4 enable gating");

		write_control(32'h3);
		check_model();
		send_samples(100, 1'b0);
		check_model();
		report_test("5 clear");

		write_control(32'h3);
		send_samples(100, 1'b1);
		check_model();
		// a clear after saturation releases the sticky overflow bits
		write_control(32'h2);
		check_model();
		report_test("6 saturation");

		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			assert_failures);
		if (errors == 0 && assert_failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/corr_pkg.sv
verilog/sample_delay_line.sv
verilog/baseline_accumulator.sv
verilog/corr_regs.sv
verilog/correlator_top.sv
test/tb_clock_gen.sv
test/correlator_asserts.sv
test/correlator_tb.sv
